/* bench/pipeline_cases.txt */
// word 0: program length in words, word 1: number of expected stores
// then one program word per line, then expected stores as address data pairs
00000018
00000008
00500093 // 00: addi x1, x0, 5
ffd00113 // 04: addi x2, x0, -3
002081b3 // 08: add  x3, x1, x2
40208233 // 0c: sub  x4, x1, x2
00112333 // 10: slt  x6, x2, x1
00302023 // 14: sw   x3, 0(x0)
00402223 // 18: sw   x4, 4(x0)
0041e3b3 // 1c: or   x7, x3, x4
00702423 // 20: sw   x7, 8(x0)
00602623 // 24: sw   x6, 12(x0)
00402403 // 28: lw   x8, 4(x0)
001404b3 // 2c: add  x9, x8, x1
00902823 // 30: sw   x9, 16(x0)
00108663 // 34: beq  x1, x1, +12
00102a23 // 38: sw   x1, 20(x0)   skipped
00202a23 // 3c: sw   x2, 20(x0)   skipped
00208463 // 40: beq  x1, x2, +8   falls through
0023f533 // 44: and  x10, x7, x2
00a02a23 // 48: sw   x10, 20(x0)
00c005ef // 4c: jal  x11, +12
00102c23 // 50: sw   x1, 24(x0)   skipped
00202c23 // 54: sw   x2, 24(x0)   skipped
00b02c23 // 58: sw   x11, 24(x0)
00202e23 // 5c: sw   x2, 28(x0)
00000000 00000002
00000004 00000008
00000008 0000000a
0000000c 00000001
00000010 0000000d
00000014 00000008
00000018 00000050
0000001c fffffffd

/* list.f */
rtl/rv_pkg.sv
rtl/instr_fetch.sv
rtl/instr_decode.sv
rtl/exec.sv
rtl/hazard_unit.sv
rtl/riscv_pipeline.sv
bench/tb_riscv_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_riscv_pipeline
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_riscv_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_pipeline
    import rv_pkg::*;
();

    localparam int              mem_words       = 64;
    localparam int              case_words      = 256;
    // jal x0, 0
    localparam logic [xlen-1:0] self_loop_instr = 32'h0000_006f;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] read_data;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] data_addr;
    logic [xlen-1:0] din;
    logic            data_we;

    logic [xlen-1:0] case_mem [case_words];
    logic [xlen-1:0] imem [mem_words];
    logic [xlen-1:0] dmem [mem_words];

    int              prog_len;
    int              store_cnt;
    int              store_idx   = 0;
    int              cycle_cnt   = 0;
    int              cycle_limit = 0;

    riscv_pipeline dut_i (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .read_data (read_data),
        .pc        (pc),
        .data_addr (data_addr),
        .din       (din),
        .data_we   (data_we)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // both memories answer in the same cycle
    assign instr     = imem[pc[7:2]];
    assign read_data = dmem[data_addr[7:2]];

    // fill marks each word with its own byte address
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                dmem[i] <= 32'hdada_0000 | (i << 2);
            end
        end else if (data_we) begin
            dmem[data_addr[7:2]] <= din;
        end
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [xlen-1:0] expected,
                                   input logic [xlen-1:0] actual);
        $display("ERR %s expected %h actual %h", name, expected, actual);
        abort_run();
    endtask

    task automatic load_cases();
        for (int i = 0; i < case_words; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("bench/pipeline_cases.txt", case_mem);
        prog_len  = int'(case_mem[0]);
        store_cnt = int'(case_mem[1]);
        if (prog_len < 1 || prog_len > mem_words || store_cnt < 1 ||
            store_cnt > (case_words - 2 - prog_len) / 2) begin
            $display("cases file is missing or its word counts are out of range");
            abort_run();
        end else begin
            for (int i = 0; i < mem_words; i++) begin
                imem[i] = (i < prog_len) ? case_mem[2 + i] : self_loop_instr;
            end
            cycle_limit = 20 * prog_len + 50;
        end
    endtask

    task automatic verify_reset_state();
        assert (data_we === 1'b0)
            else report_mismatch("data_we", '0, xlen'(data_we));
        assert (pc === reset_pc)
            else report_mismatch("pc", reset_pc, pc);
    endtask

    task automatic compare_store();
        int              base;
        logic [xlen-1:0] exp_addr;
        logic [xlen-1:0] exp_data;
        if (store_idx >= store_cnt) begin
            $display("store to address %h came after the last expected store", data_addr);
            abort_run();
        end else begin
            base     = 2 + prog_len + 2 * store_idx;
            exp_addr = case_mem[base];
            exp_data = case_mem[base + 1];
            assert (data_addr === exp_addr)
                else report_mismatch("data_addr", exp_addr, data_addr);
            assert (din === exp_data)
                else report_mismatch("din", exp_data, din);
            store_idx++;
        end
    endtask

    // store ports are stable mid-cycle, ahead of the writing edge
    always @(negedge clk) begin
        if (rst === 1'b0 && data_we === 1'b1) begin
            compare_store();
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d expected stores seen",
                     cycle_cnt, store_idx, store_cnt);
            abort_run();
        end
    end

    initial begin
        rst = 1'b1;
        load_cases();
        repeat (3) begin
            @(negedge clk);
            verify_reset_state();
        end
        rst = 1'b0;
        // first cycle out of reset still fetches from reset_pc
        verify_reset_state();

        while (store_idx < store_cnt) begin
            @(negedge clk);
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/riscv_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_pipeline
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] read_data,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] data_addr,
    output logic [xlen-1:0] din,
    output logic            data_we
);

    logic [xlen-1:0]       pc_plus4_f;
    logic [xlen-1:0]       instr_d;
    logic [xlen-1:0]       pc_d;
    logic [xlen-1:0]       pc_plus4_d;

    logic                  reg_write_d;
    logic                  mem_write_d;
    logic                  jump_d;
    logic                  branch_d;
    logic                  alu_src_d;
    rv_pkg::result_src_e   result_src_d;
    rv_pkg::alu_op_e       alu_op_d;
    logic [xlen-1:0]       rd1_d;
    logic [xlen-1:0]       rd2_d;
    logic [xlen-1:0]       imm_ext_d;
    logic [reg_addr_w-1:0] rs1_d;
    logic [reg_addr_w-1:0] rs2_d;
    logic [reg_addr_w-1:0] rd_d;

    logic                  reg_write_e;
    logic                  mem_write_e;
    logic                  jump_e;
    logic                  branch_e;
    logic                  alu_src_e;
    rv_pkg::result_src_e   result_src_e;
    rv_pkg::alu_op_e       alu_op_e;
    logic [xlen-1:0]       rd1_e;
    logic [xlen-1:0]       rd2_e;
    logic [xlen-1:0]       imm_ext_e;
    logic [xlen-1:0]       pc_e;
    logic [xlen-1:0]       pc_plus4_e;
    logic [reg_addr_w-1:0] rs1_e;
    logic [reg_addr_w-1:0] rs2_e;
    logic [reg_addr_w-1:0] rd_e;
    logic [xlen-1:0]       alu_result_e;
    logic [xlen-1:0]       write_data_e;
    logic [xlen-1:0]       pc_target_e;
    logic                  pc_src_e;

    logic                  reg_write_m;
    logic                  mem_write_m;
    rv_pkg::result_src_e   result_src_m;
    logic [xlen-1:0]       alu_result_m;
    logic [xlen-1:0]       write_data_m;
    logic [xlen-1:0]       pc_plus4_m;
    logic [reg_addr_w-1:0] rd_m;

    logic                  reg_write_w;
    rv_pkg::result_src_e   result_src_w;
    logic [xlen-1:0]       alu_result_w;
    logic [xlen-1:0]       read_data_w;
    logic [xlen-1:0]       pc_plus4_w;
    logic [reg_addr_w-1:0] rd_w;
    logic [xlen-1:0]       result_w;

    logic                  stall_f;
    logic                  stall_d;
    logic                  flush_d;
    logic                  flush_e;
    fwd_sel_e              forward_a;
    fwd_sel_e              forward_b;

    instr_fetch i_instr_fetch (
        .clk       (clk),
        .rst       (rst),
        .stall_f   (stall_f),
        .pc_src    (pc_src_e),
        .pc_target (pc_target_e),
        .pc        (pc),
        .pc_plus4  (pc_plus4_f)
    );

    // decode registers, a flushed slot becomes a nop
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            instr_d <= nop_instr;
        end else if (!stall_d) begin
            instr_d <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            pc_d       <= pc;
            pc_plus4_d <= pc_plus4_f;
        end
    end

    instr_decode i_instr_decode (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr_d),
        .reg_write_w (reg_write_w),
        .rd_w        (rd_w),
        .result_w    (result_w),
        .reg_write   (reg_write_d),
        .mem_write   (mem_write_d),
        .jump        (jump_d),
        .branch      (branch_d),
        .alu_src     (alu_src_d),
        .result_src  (result_src_d),
        .alu_op      (alu_op_d),
        .rd1         (rd1_d),
        .rd2         (rd2_d),
        .imm_ext     (imm_ext_d),
        .rs1         (rs1_d),
        .rs2         (rs2_d),
        .rd          (rd_d)
    );

    // execute registers, flush inserts a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            jump_e       <= 1'b0;
            branch_e     <= 1'b0;
            alu_src_e    <= 1'b0;
            result_src_e <= res_alu;
            alu_op_e     <= alu_add;
        end else begin
            reg_write_e  <= reg_write_d;
            mem_write_e  <= mem_write_d;
            jump_e       <= jump_d;
            branch_e     <= branch_d;
            alu_src_e    <= alu_src_d;
            result_src_e <= result_src_d;
            alu_op_e     <= alu_op_d;
        end
    end

    always_ff @(posedge clk) begin
        rd1_e      <= rd1_d;
        rd2_e      <= rd2_d;
        imm_ext_e  <= imm_ext_d;
        pc_e       <= pc_d;
        pc_plus4_e <= pc_plus4_d;
        rs1_e      <= rs1_d;
        rs2_e      <= rs2_d;
        rd_e       <= rd_d;
    end

    exec i_exec (
        .jump         (jump_e),
        .branch       (branch_e),
        .alu_src      (alu_src_e),
        .alu_op       (alu_op_e),
        .rd1          (rd1_e),
        .rd2          (rd2_e),
        .imm_ext      (imm_ext_e),
        .pc           (pc_e),
        .forward_a    (forward_a),
        .forward_b    (forward_b),
        .alu_result_m (alu_result_m),
        .result_w     (result_w),
        .alu_result   (alu_result_e),
        .write_data   (write_data_e),
        .pc_target    (pc_target_e),
        .pc_src       (pc_src_e)
    );

    // memory stage registers
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            result_src_m <= res_alu;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            result_src_m <= result_src_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m <= alu_result_e;
        write_data_m <= write_data_e;
        pc_plus4_m   <= pc_plus4_e;
        rd_m         <= rd_e;
    end

    assign data_we   = mem_write_m;
    assign data_addr = alu_result_m;
    assign din       = write_data_m;

    // write-back registers
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_w  <= 1'b0;
            result_src_w <= res_alu;
        end else begin
            reg_write_w  <= reg_write_m;
            result_src_w <= result_src_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= alu_result_m;
        read_data_w  <= read_data;
        pc_plus4_w   <= pc_plus4_m;
        rd_w         <= rd_m;
    end

    always_comb begin
        case (result_src_w)
            res_mem: result_w = read_data_w;
            res_pc4: result_w = pc_plus4_w;
            default: result_w = alu_result_w;
        endcase
    end

    hazard_unit i_hazard_unit (
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .rs1_e        (rs1_e),
        .rs2_e        (rs2_e),
        .rd_e         (rd_e),
        .rd_m         (rd_m),
        .rd_w         (rd_w),
        .result_src_e (result_src_e),
        .reg_write_m  (reg_write_m),
        .reg_write_w  (reg_write_w),
        .pc_src       (pc_src_e),
        .stall_f      (stall_f),
        .stall_d      (stall_d),
        .flush_d      (flush_d),
        .flush_e      (flush_e),
        .forward_a    (forward_a),
        .forward_b    (forward_b)
    );

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit
    import rv_pkg::*;
(
    input  logic                  [reg_addr_w-1:0] rs1_d,
    input  logic                  [reg_addr_w-1:0] rs2_d,
    input  logic                  [reg_addr_w-1:0] rs1_e,
    input  logic                  [reg_addr_w-1:0] rs2_e,
    input  logic                  [reg_addr_w-1:0] rd_e,
    input  logic                  [reg_addr_w-1:0] rd_m,
    input  logic                  [reg_addr_w-1:0] rd_w,
    input  rv_pkg::result_src_e                    result_src_e,
    input  logic                                   reg_write_m,
    input  logic                                   reg_write_w,
    input  logic                                   pc_src,
    output logic                                   stall_f,
    output logic                                   stall_d,
    output logic                                   flush_d,
    output logic                                   flush_e,
    output fwd_sel_e                               forward_a,
    output fwd_sel_e                               forward_b
);

    logic lw_stall;

    // memory stage is younger, so it takes priority
    function automatic fwd_sel_e fwd_select(input logic [reg_addr_w-1:0] rs);
        fwd_sel_e sel;
        if (rs != '0 && reg_write_m && rs == rd_m) begin
            sel = fwd_mem;
        end else if (rs != '0 && reg_write_w && rs == rd_w) begin
            sel = fwd_wb;
        end else begin
            sel = fwd_reg;
        end
        return sel;
    endfunction

    always_comb begin
        forward_a = fwd_select(rs1_e);
        forward_b = fwd_select(rs2_e);
    end

    // load result not ready until memory stage
    assign lw_stall = (result_src_e == res_mem) && (rd_e != '0) &&
                      ((rd_e == rs1_d) || (rd_e == rs2_d));

    assign stall_f = lw_stall;
    assign stall_d = lw_stall;
    assign flush_d = pc_src;
    assign flush_e = pc_src | lw_stall;

endmodule

`default_nettype wire

/* rtl/exec.sv */
`timescale 1ns/10ps
`default_nettype none

module exec
    import rv_pkg::*;
(
    input  logic            jump,
    input  logic            branch,
    input  logic            alu_src,
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] rd1,
    input  logic [xlen-1:0] rd2,
    input  logic [xlen-1:0] imm_ext,
    input  logic [xlen-1:0] pc,
    input  fwd_sel_e        forward_a,
    input  fwd_sel_e        forward_b,
    input  logic [xlen-1:0] alu_result_m,
    input  logic [xlen-1:0] result_w,
    output logic [xlen-1:0] alu_result,
    output logic [xlen-1:0] write_data,
    output logic [xlen-1:0] pc_target,
    output logic            pc_src
);

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic            operands_equal;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] reg_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] wb_val
    );
        logic [xlen-1:0] val;
        case (sel)
            fwd_mem: val = mem_val;
            fwd_wb:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign src_a      = fwd_mux(forward_a, rd1, alu_result_m, result_w);
    assign write_data = fwd_mux(forward_b, rd2, alu_result_m, result_w);
    assign src_b      = alu_src ? imm_ext : write_data;

    always_comb begin
        case (alu_op)
            alu_add: alu_result = src_a + src_b;
            alu_sub: alu_result = src_a - src_b;
            alu_and: alu_result = src_a & src_b;
            alu_or:  alu_result = src_a | src_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            default: alu_result = src_a + src_b;
        endcase
    end

    // beq compares the forwarded register operands
    assign operands_equal = (src_a == write_data);
    assign pc_target      = pc + imm_ext;
    assign pc_src         = jump | (branch & operands_equal);

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decode
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [xlen-1:0]       instr,
    input  logic                  reg_write_w,
    input  logic [reg_addr_w-1:0] rd_w,
    input  logic [xlen-1:0]       result_w,
    output logic                  reg_write,
    output logic                  mem_write,
    output logic                  jump,
    output logic                  branch,
    output logic                  alu_src,
    output result_src_e           result_src,
    output alu_op_e               alu_op,
    output logic [xlen-1:0]       rd1,
    output logic [xlen-1:0]       rd2,
    output logic [xlen-1:0]       imm_ext,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [xlen-1:0] regs [32];

    // funct7 bit 5 only matters for register-register sub
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub_bit);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_bit ? alu_sub : alu_add;
            3'b010:  op = alu_slt;
            3'b110:  op = alu_or;
            3'b111:  op = alu_and;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign rd        = instr[11:7];

    always_comb begin
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        jump       = 1'b0;
        branch     = 1'b0;
        alu_src    = 1'b0;
        result_src = res_alu;
        alu_op     = alu_add;
        imm_ext    = '0;
        case (opcode)
            op_r: begin
                reg_write = 1'b1;
                alu_op    = alu_from_funct(funct3, funct7_b5);
            end
            op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = alu_from_funct(funct3, 1'b0);
                imm_ext   = {{20{instr[31]}}, instr[31:20]};
            end
            op_load: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                result_src = res_mem;
                imm_ext    = {{20{instr[31]}}, instr[31:20]};
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_ext   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_branch: begin
                branch  = 1'b1;
                alu_op  = alu_sub;
                imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            op_jal: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                result_src = res_pc4;
                imm_ext    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

    // register file, x0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write_w && rd_w != '0) begin
            regs[rd_w] <= result_w;
        end
    end

    // same-cycle write shows up on the read ports
    assign rd1 = (rs1 == '0) ? '0 :
                 (reg_write_w && rd_w == rs1) ? result_w : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 :
                 (reg_write_w && rd_w == rs2) ? result_w : regs[rs2];

endmodule

`default_nettype wire

/* rtl/instr_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_fetch
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_f,
    input  logic            pc_src,
    input  logic [xlen-1:0] pc_target,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pc_plus4
);

    logic [xlen-1:0] pc_next;

    assign pc_plus4 = pc + xlen'(4);

    // redirect from execute wins over sequential fetch
    assign pc_next = pc_src ? pc_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (!stall_f) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_or  = 3'b011,
        alu_slt = 3'b101
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01,
        res_pc4 = 2'b10
    } result_src_e;

    // execute operand source
    typedef enum logic [1:0] {
        fwd_reg = 2'b00,
        fwd_wb  = 2'b01,
        fwd_mem = 2'b10
    } fwd_sel_e;

endpackage

`default_nettype wire
